/* hdl/dq_pkg.sv */
/*
    Widths and counts shared by the dispatch queue.
    The low LOG_PRF_BANK_COUNT bits of a register index pick its bank.
    The queue depth is a module parameter and is not defined here.
*/

package dq_pkg;

    // dispatch width
    localparam int DISPATCH_WAYS = 4;

    // register file
    localparam int LOG_PR_COUNT = 7;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PRF_BANK_COUNT = 1 << LOG_PRF_BANK_COUNT;

    // reorder buffer
    localparam int LOG_ROB_ENTRIES = 7;

    // --------------------
    // vector types

    typedef logic [LOG_PR_COUNT-1:0] pr_t;
    typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;
    typedef logic [3:0] op_t;

endpackage

/* hdl/dq_op_if.sv */
/*
    One queued ALU reg-reg or MDU operation.
    On a slot output, a_ready and b_ready already include this cycle's wakeup.
    Exactly one of is_alu_reg and is_mdu is set when valid is high.
*/

`timescale 1ns/100ps

interface dq_op_if;

    import dq_pkg::*;

    logic       valid;
    logic       is_alu_reg;
    logic       is_mdu;
    op_t        op;
    pr_t        a_pr;
    logic       a_ready;
    pr_t        b_pr;
    logic       b_ready;
    pr_t        dest_pr;
    rob_index_t rob_index;

    // producer side
    modport src (
        output valid, is_alu_reg, is_mdu, op,
        output a_pr, a_ready, b_pr, b_ready,
        output dest_pr, rob_index
    );

    // consumer side
    modport dst (
        input valid, is_alu_reg, is_mdu, op,
        input a_pr, a_ready, b_pr, b_ready,
        input dest_pr, rob_index
    );

endinterface

/* hdl/dq_entry.sv */
/*
    One slot of the collapsing dispatch queue.
    Published ready bits are the stored bits OR this cycle's writeback match.
    Ready bits of a freshly dispatched operation are stored as given.
*/

`timescale 1ns/100ps

module dq_entry (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  logic                                            shift,
    input  logic [dq_pkg::PRF_BANK_COUNT-1:0]               wb_valid_by_bank,
    input  dq_pkg::upper_pr_t [dq_pkg::PRF_BANK_COUNT-1:0]  wb_upper_pr_by_bank,
    dq_op_if.dst                                            disp_self,
    dq_op_if.dst                                            disp_above,
    dq_op_if.dst                                            slot_above,
    dq_op_if.src                                            slot
);

    import dq_pkg::*;

    logic       valid_q;
    logic       is_alu_reg_q;
    logic       is_mdu_q;
    op_t        op_q;
    pr_t        a_pr_q;
    logic       a_ready_q;
    pr_t        b_pr_q;
    logic       b_ready_q;
    pr_t        dest_pr_q;
    rob_index_t rob_index_q;

    // writeback hit on the bank that the register lives in
    function automatic logic wake_hit(input pr_t pr);
        logic [LOG_PRF_BANK_COUNT-1:0] bank;
        bank = pr[LOG_PRF_BANK_COUNT-1:0];
        return wb_valid_by_bank[bank]
            & (wb_upper_pr_by_bank[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    assign slot.valid = valid_q;
    assign slot.is_alu_reg = is_alu_reg_q;
    assign slot.is_mdu = is_mdu_q;
    assign slot.op = op_q;
    assign slot.a_pr = a_pr_q;
    assign slot.b_pr = b_pr_q;
    assign slot.dest_pr = dest_pr_q;
    assign slot.rob_index = rob_index_q;

    always_comb begin
        slot.a_ready = a_ready_q | wake_hit(a_pr_q);
        slot.b_ready = b_ready_q | wake_hit(b_pr_q);
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= 1'b0;
        end else if (shift) begin
            valid_q <= slot_above.valid | disp_above.valid;
        end else if (!valid_q) begin
            valid_q <= disp_self.valid;
        end
    end

    // payload, held by default with ready bits picking up wakeups
    always_ff @(posedge CLK) begin
        a_ready_q <= slot.a_ready;
        b_ready_q <= slot.b_ready;
        if (shift && slot_above.valid) begin
            {is_alu_reg_q, is_mdu_q, op_q} <= {slot_above.is_alu_reg, slot_above.is_mdu,
                                               slot_above.op};
            {a_pr_q, a_ready_q} <= {slot_above.a_pr, slot_above.a_ready};
            {b_pr_q, b_ready_q} <= {slot_above.b_pr, slot_above.b_ready};
            {dest_pr_q, rob_index_q} <= {slot_above.dest_pr, slot_above.rob_index};
        end else if (shift) begin
            {is_alu_reg_q, is_mdu_q, op_q} <= {disp_above.is_alu_reg, disp_above.is_mdu,
                                               disp_above.op};
            {a_pr_q, a_ready_q} <= {disp_above.a_pr, disp_above.a_ready};
            {b_pr_q, b_ready_q} <= {disp_above.b_pr, disp_above.b_ready};
            {dest_pr_q, rob_index_q} <= {disp_above.dest_pr, disp_above.rob_index};
        end else if (!valid_q) begin
            {is_alu_reg_q, is_mdu_q, op_q} <= {disp_self.is_alu_reg, disp_self.is_mdu,
                                               disp_self.op};
            {a_pr_q, a_ready_q} <= {disp_self.a_pr, disp_self.a_ready};
            {b_pr_q, b_ready_q} <= {disp_self.b_pr, disp_self.b_ready};
            {dest_pr_q, rob_index_q} <= {disp_self.dest_pr, disp_self.rob_index};
        end
    end

endmodule

/* hdl/dq_alloc_ctrl.sv */
/*
    Slot allocation, dispatch crossbar and head launch for the dispatch queue.
    Free slots come from the current valids only, a same-cycle launch does not
    free one. An attempting way must set exactly one class bit.
*/

`timescale 1ns/100ps

module dq_alloc_ctrl #(
    parameter int ENTRIES = 4
) (
    // dispatch ways
    input  logic [dq_pkg::DISPATCH_WAYS-1:0]                      dispatch_attempt_by_way,
    input  logic [dq_pkg::DISPATCH_WAYS-1:0]                      dispatch_valid_alu_reg_by_way,
    input  logic [dq_pkg::DISPATCH_WAYS-1:0]                      dispatch_valid_mdu_by_way,
    input  dq_pkg::op_t [dq_pkg::DISPATCH_WAYS-1:0]               dispatch_op_by_way,
    input  dq_pkg::pr_t [dq_pkg::DISPATCH_WAYS-1:0]               dispatch_a_pr_by_way,
    input  logic [dq_pkg::DISPATCH_WAYS-1:0]                      dispatch_a_ready_by_way,
    input  dq_pkg::pr_t [dq_pkg::DISPATCH_WAYS-1:0]               dispatch_b_pr_by_way,
    input  logic [dq_pkg::DISPATCH_WAYS-1:0]                      dispatch_b_ready_by_way,
    input  dq_pkg::pr_t [dq_pkg::DISPATCH_WAYS-1:0]               dispatch_dest_pr_by_way,
    input  dq_pkg::rob_index_t [dq_pkg::DISPATCH_WAYS-1:0]        dispatch_rob_index_by_way,
    output logic [dq_pkg::DISPATCH_WAYS-1:0]                      dispatch_ack_by_way,

    // slots
    dq_op_if.dst                                                  slot_bus [ENTRIES],
    dq_op_if.src                                                  disp_bus [ENTRIES],
    output logic                                                  shift,

    // issue queue
    input  logic                                                  iq_enq_ready,
    output logic                                                  iq_enq_valid,
    output logic                                                  iq_enq_is_alu_reg,
    output logic                                                  iq_enq_is_mdu,
    output dq_pkg::op_t                                           iq_enq_op,
    output dq_pkg::pr_t                                           iq_enq_a_pr,
    output logic                                                  iq_enq_a_ready,
    output dq_pkg::pr_t                                           iq_enq_b_pr,
    output logic                                                  iq_enq_b_ready,
    output dq_pkg::pr_t                                           iq_enq_dest_pr,
    output dq_pkg::rob_index_t                                    iq_enq_rob_index
);

    import dq_pkg::*;

    logic [ENTRIES-1:0]                     valid_by_entry;
    logic [DISPATCH_WAYS-1:0][ENTRIES-1:0]  one_hot_by_way;

    function automatic logic [ENTRIES-1:0] lowest_set(input logic [ENTRIES-1:0] mask);
        return mask & (~mask + 1'b1);
    endfunction

    for (genvar i = 0; i < ENTRIES; i++) begin : g_valid
        assign valid_by_entry[i] = slot_bus[i].valid;
    end

    // --------------------
    // slot allocation

    // each way claims the lowest slot left by the ways below it
    always_comb begin
        logic [ENTRIES-1:0] avail;
        avail = ~valid_by_entry;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            one_hot_by_way[w] = lowest_set(avail) & {ENTRIES{dispatch_attempt_by_way[w]}};
            dispatch_ack_by_way[w] = dispatch_attempt_by_way[w] & (|avail);
            avail = avail & ~one_hot_by_way[w];
        end
    end

    // --------------------
    // dispatch crossbar

    for (genvar i = 0; i < ENTRIES; i++) begin : g_xbar
        always_comb begin
            disp_bus[i].valid = 1'b0;
            disp_bus[i].is_alu_reg = 1'b0;
            disp_bus[i].is_mdu = 1'b0;
            disp_bus[i].op = '0;
            disp_bus[i].a_pr = '0;
            disp_bus[i].a_ready = 1'b0;
            disp_bus[i].b_pr = '0;
            disp_bus[i].b_ready = 1'b0;
            disp_bus[i].dest_pr = '0;
            disp_bus[i].rob_index = '0;
            // at most one way targets a slot, so OR acts as the mux
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                if (one_hot_by_way[w][i]) begin
                    disp_bus[i].valid |= dispatch_valid_alu_reg_by_way[w]
                                       | dispatch_valid_mdu_by_way[w];
                    disp_bus[i].is_alu_reg |= dispatch_valid_alu_reg_by_way[w];
                    disp_bus[i].is_mdu |= dispatch_valid_mdu_by_way[w];
                    disp_bus[i].op |= dispatch_op_by_way[w];
                    disp_bus[i].a_pr |= dispatch_a_pr_by_way[w];
                    disp_bus[i].a_ready |= dispatch_a_ready_by_way[w];
                    disp_bus[i].b_pr |= dispatch_b_pr_by_way[w];
                    disp_bus[i].b_ready |= dispatch_b_ready_by_way[w];
                    disp_bus[i].dest_pr |= dispatch_dest_pr_by_way[w];
                    disp_bus[i].rob_index |= dispatch_rob_index_by_way[w];
                end
            end
        end
    end

    // --------------------
    // head launch

    assign shift = slot_bus[0].valid & iq_enq_ready;

    assign iq_enq_valid = shift;
    assign iq_enq_is_alu_reg = slot_bus[0].is_alu_reg;
    assign iq_enq_is_mdu = slot_bus[0].is_mdu;
    assign iq_enq_op = slot_bus[0].op;
    assign iq_enq_a_pr = slot_bus[0].a_pr;
    assign iq_enq_a_ready = slot_bus[0].a_ready;
    assign iq_enq_b_pr = slot_bus[0].b_pr;
    assign iq_enq_b_ready = slot_bus[0].b_ready;
    assign iq_enq_dest_pr = slot_bus[0].dest_pr;
    assign iq_enq_rob_index = slot_bus[0].rob_index;

endmodule

/* hdl/alu_reg_mdu_dq.sv */
/*
    ALU reg-reg and MDU dispatch queue, collapsing toward slot 0.
    Up to four ways dispatch per cycle, the head launches when the IQ is ready.
    ENTRIES must be 2 or more.
*/

`timescale 1ns/100ps

module alu_reg_mdu_dq #(
    parameter int ENTRIES = 4
) (
    input  logic                                              CLK,
    input  logic                                              nRST,

    // dispatch ways
    input  logic [dq_pkg::DISPATCH_WAYS-1:0]                  dispatch_attempt_by_way,
    input  logic [dq_pkg::DISPATCH_WAYS-1:0]                  dispatch_valid_alu_reg_by_way,
    input  logic [dq_pkg::DISPATCH_WAYS-1:0]                  dispatch_valid_mdu_by_way,
    input  dq_pkg::op_t [dq_pkg::DISPATCH_WAYS-1:0]           dispatch_op_by_way,
    input  dq_pkg::pr_t [dq_pkg::DISPATCH_WAYS-1:0]           dispatch_a_pr_by_way,
    input  logic [dq_pkg::DISPATCH_WAYS-1:0]                  dispatch_a_ready_by_way,
    input  dq_pkg::pr_t [dq_pkg::DISPATCH_WAYS-1:0]           dispatch_b_pr_by_way,
    input  logic [dq_pkg::DISPATCH_WAYS-1:0]                  dispatch_b_ready_by_way,
    input  dq_pkg::pr_t [dq_pkg::DISPATCH_WAYS-1:0]           dispatch_dest_pr_by_way,
    input  dq_pkg::rob_index_t [dq_pkg::DISPATCH_WAYS-1:0]    dispatch_rob_index_by_way,
    output logic [dq_pkg::DISPATCH_WAYS-1:0]                  dispatch_ack_by_way,

    // writeback bus
    input  logic [dq_pkg::PRF_BANK_COUNT-1:0]                 wb_valid_by_bank,
    input  dq_pkg::upper_pr_t [dq_pkg::PRF_BANK_COUNT-1:0]    wb_upper_pr_by_bank,

    // issue queue
    input  logic                                              iq_enq_ready,
    output logic                                              iq_enq_valid,
    output logic                                              iq_enq_is_alu_reg,
    output logic                                              iq_enq_is_mdu,
    output dq_pkg::op_t                                       iq_enq_op,
    output dq_pkg::pr_t                                       iq_enq_a_pr,
    output logic                                              iq_enq_a_ready,
    output dq_pkg::pr_t                                       iq_enq_b_pr,
    output logic                                              iq_enq_b_ready,
    output dq_pkg::pr_t                                       iq_enq_dest_pr,
    output dq_pkg::rob_index_t                                iq_enq_rob_index
);

    logic shift;

    dq_op_if disp_bus [ENTRIES] ();
    dq_op_if slot_bus [ENTRIES] ();

    // empty neighbor above the top slot
    dq_op_if tie_above ();

    assign tie_above.valid = 1'b0;
    assign tie_above.is_alu_reg = 1'b0;
    assign tie_above.is_mdu = 1'b0;
    assign tie_above.op = '0;
    assign tie_above.a_pr = '0;
    assign tie_above.a_ready = 1'b0;
    assign tie_above.b_pr = '0;
    assign tie_above.b_ready = 1'b0;
    assign tie_above.dest_pr = '0;
    assign tie_above.rob_index = '0;

    dq_alloc_ctrl #(
        .ENTRIES(ENTRIES)
    ) u_alloc_ctrl (
        .dispatch_attempt_by_way,
        .dispatch_valid_alu_reg_by_way,
        .dispatch_valid_mdu_by_way,
        .dispatch_op_by_way,
        .dispatch_a_pr_by_way,
        .dispatch_a_ready_by_way,
        .dispatch_b_pr_by_way,
        .dispatch_b_ready_by_way,
        .dispatch_dest_pr_by_way,
        .dispatch_rob_index_by_way,
        .dispatch_ack_by_way,
        .slot_bus(slot_bus),
        .disp_bus(disp_bus),
        .shift,
        .iq_enq_ready,
        .iq_enq_valid,
        .iq_enq_is_alu_reg,
        .iq_enq_is_mdu,
        .iq_enq_op,
        .iq_enq_a_pr,
        .iq_enq_a_ready,
        .iq_enq_b_pr,
        .iq_enq_b_ready,
        .iq_enq_dest_pr,
        .iq_enq_rob_index
    );

    // --------------------
    // slots, 0 is the head

    for (genvar i = 0; i < ENTRIES; i++) begin : g_entry
        if (i == ENTRIES - 1) begin : g_top
            dq_entry u_entry (
                .CLK, .nRST, .shift, .wb_valid_by_bank, .wb_upper_pr_by_bank,
                .disp_self(disp_bus[i]),
                .disp_above(tie_above),
                .slot_above(tie_above),
                .slot(slot_bus[i])
            );
        end else begin : g_low
            dq_entry u_entry (
                .CLK, .nRST, .shift, .wb_valid_by_bank, .wb_upper_pr_by_bank,
                .disp_self(disp_bus[i]),
                .disp_above(disp_bus[i+1]),
                .slot_above(slot_bus[i+1]),
                .slot(slot_bus[i])
            );
        end
    end

endmodule

/* testbench/alu_reg_mdu_dq_asserts.sv */
/*
    Port protocol checks for the dispatch queue, bound to the top level.
    All checks are off while nRST is low.
*/

`timescale 1ns/100ps

module alu_reg_mdu_dq_asserts (
    input logic                               CLK,
    input logic                               nRST,
    input logic [dq_pkg::DISPATCH_WAYS-1:0]   dispatch_attempt_by_way,
    input logic [dq_pkg::DISPATCH_WAYS-1:0]   dispatch_valid_alu_reg_by_way,
    input logic [dq_pkg::DISPATCH_WAYS-1:0]   dispatch_valid_mdu_by_way,
    input logic [dq_pkg::DISPATCH_WAYS-1:0]   dispatch_ack_by_way,
    input logic                               iq_enq_ready,
    input logic                               iq_enq_valid
);

    // exactly one class bit on every attempting way
    a_class_one_hot: assert property (@(posedge CLK) disable iff (!nRST)
        ((dispatch_valid_alu_reg_by_way ^ dispatch_valid_mdu_by_way) & dispatch_attempt_by_way)
            == dispatch_attempt_by_way)
        else $error("attempting way without exactly one class bit");

    a_ack_needs_attempt: assert property (@(posedge CLK) disable iff (!nRST)
        (dispatch_ack_by_way & ~dispatch_attempt_by_way) == '0)
        else $error("acknowledge on a way that does not attempt");

    a_launch_needs_ready: assert property (@(posedge CLK) disable iff (!nRST)
        !(iq_enq_valid && !iq_enq_ready))
        else $error("launch while the issue queue is not ready");

endmodule

bind alu_reg_mdu_dq alu_reg_mdu_dq_asserts u_asserts (
    .CLK, .nRST, .dispatch_attempt_by_way, .dispatch_valid_alu_reg_by_way,
    .dispatch_valid_mdu_by_way, .dispatch_ack_by_way, .iq_enq_ready, .iq_enq_valid
);

/* testbench/tb_alu_reg_mdu_dq.sv */
/*
    Random testbench for the dispatch queue with ENTRIES 4, checked against a queue model.
    Inputs change on the falling edge, outputs are checked 1 ns later.
*/

`timescale 1ns/100ps

module tb_alu_reg_mdu_dq;

    import dq_pkg::*;

    localparam int ENTRIES = 4;
    localparam int NUM_CYCLES = 2000;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

    typedef struct packed {
        logic       is_alu_reg;
        logic       is_mdu;
        op_t        op;
        pr_t        a_pr;
        logic       a_ready;
        pr_t        b_pr;
        logic       b_ready;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } op_rec_t;

    logic CLK, nRST, iq_enq_ready;
    logic [DISPATCH_WAYS-1:0] dispatch_attempt_by_way, dispatch_valid_alu_reg_by_way,
        dispatch_valid_mdu_by_way, dispatch_a_ready_by_way, dispatch_b_ready_by_way,
        dispatch_ack_by_way;
    op_t [DISPATCH_WAYS-1:0] dispatch_op_by_way;
    pr_t [DISPATCH_WAYS-1:0] dispatch_a_pr_by_way, dispatch_b_pr_by_way, dispatch_dest_pr_by_way;
    rob_index_t [DISPATCH_WAYS-1:0] dispatch_rob_index_by_way;
    logic [PRF_BANK_COUNT-1:0] wb_valid_by_bank;
    upper_pr_t [PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank;
    logic iq_enq_valid, iq_enq_is_alu_reg, iq_enq_is_mdu, iq_enq_a_ready, iq_enq_b_ready;
    op_t iq_enq_op;
    pr_t iq_enq_a_pr, iq_enq_b_pr, iq_enq_dest_pr;
    rob_index_t iq_enq_rob_index;

    op_rec_t model_q[$];
    int seed = 32'h2e17;
    int errors, checks, launches, full_cycles, cycle_count;

    alu_reg_mdu_dq #(.ENTRIES(ENTRIES)) u_dut (.*);

    // a writeback bank names the register by its upper bits
    function automatic logic wb_hit(input pr_t pr);
        return wb_valid_by_bank[pr[LOG_PRF_BANK_COUNT-1:0]]
            && wb_upper_pr_by_bank[pr[LOG_PRF_BANK_COUNT-1:0]]
               == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
    endfunction

    function automatic op_rec_t woken(input op_rec_t r);
        op_rec_t t;
        t = r;
        t.a_ready = r.a_ready | wb_hit(r.a_pr);
        t.b_ready = r.b_ready | wb_hit(r.b_pr);
        return t;
    endfunction

    // phases of 100 cycles: sparse, drain, long back-pressure, mixed
    task automatic drive_inputs(input int cyc);
        int phase;
        int pick;
        logic [31:0] rnd;
        logic [31:0] rnd2;
        pr_t src;
        phase = (cyc / 100) % 4;
        rnd = $random(seed);
        if (phase == 2 && cyc % 100 < 60)
            iq_enq_ready = 1'b0;
        else
            iq_enq_ready = (phase == 1) || (rnd[1:0] != 2'd0);
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            rnd = $random(seed);
            rnd2 = $random(seed);
            dispatch_attempt_by_way[w] = (phase == 0) ? (rnd[1:0] == 2'd0) : rnd[0];
            // non-attempting ways carry junk class bits
            dispatch_valid_alu_reg_by_way[w] = dispatch_attempt_by_way[w] ? rnd[2] : rnd[3];
            dispatch_valid_mdu_by_way[w] = dispatch_attempt_by_way[w] ? !rnd[2] : rnd[4];
            dispatch_op_by_way[w] = rnd[8:5];
            dispatch_a_pr_by_way[w] = rnd[15:9];
            dispatch_b_pr_by_way[w] = rnd[22:16];
            dispatch_dest_pr_by_way[w] = rnd[29:23];
            dispatch_rob_index_by_way[w] = rnd2[6:0];
            dispatch_a_ready_by_way[w] = rnd2[8:7] == 2'd0;
            dispatch_b_ready_by_way[w] = rnd2[10:9] == 2'd0;
        end
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            rnd = $random(seed);
            wb_valid_by_bank[b] = rnd[0];
            wb_upper_pr_by_bank[b] = rnd[7:3];
        end
        // aim a writeback at a queued source half of the time
        rnd = $random(seed);
        if (model_q.size() > 0 && rnd[0]) begin
            pick = int'(rnd[9:2]) % model_q.size();
            src = rnd[1] ? model_q[pick].a_pr : model_q[pick].b_pr;
            wb_valid_by_bank[src[LOG_PRF_BANK_COUNT-1:0]] = 1'b1;
            wb_upper_pr_by_bank[src[LOG_PRF_BANK_COUNT-1:0]] =
                src[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
        end
    endtask

    task automatic check_and_update();
        logic [DISPATCH_WAYS-1:0] exp_ack;
        logic launch;
        op_rec_t seen;
        op_rec_t rec;
        int taken;
        taken = 0;
        exp_ack = '0;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            if (dispatch_attempt_by_way[w]) begin
                exp_ack[w] = taken < ENTRIES - model_q.size();
                taken++;
            end
        end
        launch = model_q.size() > 0 && iq_enq_ready;
        checks += 2;
        if (dispatch_ack_by_way !== exp_ack) begin
            errors++;
            $display("[ERROR] %0t: ack %b, expected %b with %0d queued",
                     $time, dispatch_ack_by_way, exp_ack, model_q.size());
        end
        if (iq_enq_valid !== launch) begin
            errors++;
            $display("[ERROR] %0t: iq_enq_valid %b, expected %b", $time, iq_enq_valid, launch);
        end
        if (model_q.size() == ENTRIES && !iq_enq_ready)
            full_cycles++;
        if (launch) begin
            seen = {iq_enq_is_alu_reg, iq_enq_is_mdu, iq_enq_op, iq_enq_a_pr, iq_enq_a_ready,
                    iq_enq_b_pr, iq_enq_b_ready, iq_enq_dest_pr, iq_enq_rob_index};
            checks++;
            launches++;
            if (seen !== woken(model_q[0])) begin
                errors++;
                $display("[ERROR] %0t: launched %h, expected %h",
                         $time, seen, woken(model_q[0]));
            end
        end
        // next state of the model queue
        for (int k = 0; k < model_q.size(); k++)
            model_q[k] = woken(model_q[k]);
        if (launch)
            model_q.delete(0);
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            if (exp_ack[w]) begin
                rec = {dispatch_valid_alu_reg_by_way[w], dispatch_valid_mdu_by_way[w],
                       dispatch_op_by_way[w], dispatch_a_pr_by_way[w], dispatch_a_ready_by_way[w],
                       dispatch_b_pr_by_way[w], dispatch_b_ready_by_way[w],
                       dispatch_dest_pr_by_way[w], dispatch_rob_index_by_way[w]};
                model_q.push_back(rec);
            end
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        nRST = 1'b0;
        errors = 0;
        checks = 0;
        launches = 0;
        full_cycles = 0;
        drive_inputs(0);
        dispatch_attempt_by_way = '0;
        iq_enq_ready = 1'b0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        // ----------------------
        // all four ways into the empty queue, with the IQ ready
        drive_inputs(0);
        iq_enq_ready = 1'b1;
        dispatch_attempt_by_way = '1;
        dispatch_valid_alu_reg_by_way = 4'b0101;
        dispatch_valid_mdu_by_way = 4'b1010;
        #1;
        checks++;
        if (dispatch_ack_by_way !== 4'b1111 || iq_enq_valid !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t: after reset ack %b, iq_enq_valid %b",
                     $time, dispatch_ack_by_way, iq_enq_valid);
        end
        check_and_update();
        // ----------------------
        // random run
        for (int cyc = 1; cyc <= NUM_CYCLES; cyc++) begin
            @(negedge CLK);
            drive_inputs(cyc);
            #1;
            check_and_update();
        end
        if (full_cycles == 0 || launches == 0) begin
            errors++;
            $display("the queue never filled under back-pressure or never launched");
        end
        $display("checks %0d, errors %0d, launches %0d, full cycles %0d",
                 checks, errors, launches, full_cycles);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* filelist.f */
hdl/dq_pkg.sv
hdl/dq_op_if.sv
hdl/dq_entry.sv
hdl/dq_alloc_ctrl.sv
hdl/alu_reg_mdu_dq.sv
testbench/alu_reg_mdu_dq_asserts.sv
testbench/tb_alu_reg_mdu_dq.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_alu_reg_mdu_dq \
    -o sim_tb || exit 1
./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
grep -q "Checks failed" sim.log && exit 1
[ "$status" -eq 0 ] && grep -q "All checks passed" sim.log || exit 1
echo "simulation finished without failures"
